// ==== flist.f ====
lsu_pkg.sv
lsu_lanes.sv
lsu_clint.sv
lsu_ctrl.sv
lsu_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
lsu_chk.sv
lsu_tb.sv

// ==== lsu_chk.sv ====
`timescale 1ns/1ps

module lsu_chk import lsu_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input lsu_req_t req,
    input logic     done,
    input axi_aw_t  aw,
    input logic     awvalid,
    input logic     awready,
    input axi_w_t   w,
    input logic     wvalid,
    input logic     wready,
    input logic     bready,
    input axi_ar_t  ar,
    input logic     arvalid,
    input logic     arready,
    input logic     rready
);

    // bytes moved by one beat of the given size
    function automatic int size_bytes(lsu_size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // one strobe bit per lane inside the accessed byte range
    function automatic logic [3:0] expected_strb(lsu_size_e size, logic [1:0] off);
        logic [3:0] strb;
        for (int i = 0; i < 4; i++) begin
            strb[i] = (i >= int'(off)) && (i < int'(off) + size_bytes(size));
        end
        return strb;
    endfunction

    // store bytes move up by the offset and zeros fill the lanes below
    function automatic logic lanes_shifted(logic [31:0] data, logic [31:0] wdata,
                                           logic [1:0] off);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(off)) begin
                ok = ok && (data[8*i +: 8] == 8'h00);
            end else begin
                ok = ok && (data[8*i +: 8] == wdata[8*(i - int'(off)) +: 8]);
            end
        end
        return ok;
    endfunction

    // valid holds with stable payload until ready
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW valid or payload changed before handshake");
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W valid or payload changed before handshake");
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR valid or payload changed before handshake");

    // one transaction at a time
    one_out: assert property (@(posedge clk) disable iff (!rst_n)
        !(awvalid && arvalid) && !((bready || rready) && (awvalid || arvalid || wvalid)))
        else $error("more than one AXI transaction in flight");

    // address channels carry one beat of the request's size with id 0
    aw_fields: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> aw.addr == req.addr.full && aw.len == '0 && aw.id == '0
                && aw.burst == '0 && (1 << aw.size) == size_bytes(req.size))
        else $error("AW fields do not match the request");
    ar_fields: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> ar.addr == req.addr.full && ar.len == '0 && ar.id == '0
                && ar.burst == '0 && (1 << ar.size) == size_bytes(req.size))
        else $error("AR fields do not match the request");

    // lane rules on the write beat
    w_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> w.strb == expected_strb(req.size, req.addr.part.byte_off)
               && lanes_shifted(w.data, req.wdata, req.addr.part.byte_off))
        else $error("write strobes or data lanes wrong");
    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> w.last)
        else $error("write beat without last");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done longer than one cycle");

endmodule

bind lsu_top lsu_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .done    (done),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .bready  (bready),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .rready  (rready)
);

// ==== lsu_clint.sv ====
`timescale 1ns/1ps

module lsu_clint #(
    parameter int unsigned mtime_step = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd,
    input  logic        idx,
    output logic [31:0] rdata
);

    logic [63:0] mtime;

    // free-running, software has no write path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'(mtime_step);
        end
    end

    // idx 0 is the low word at the window base, idx 1 the high word
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= idx ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // core side
    input  logic        req_valid,
    input  lsu_req_t    req,
    output logic        busy,
    output logic        done,
    output lsu_rsp_t    rsp,

    // AXI master
    output axi_aw_t     aw,
    output logic        awvalid,
    input  logic        awready,
    output axi_w_t      w,
    output logic        wvalid,
    input  logic        wready,
    input  axi_b_t      b,
    input  logic        bvalid,
    output logic        bready,
    output axi_ar_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  axi_r_t      r,
    input  logic        rvalid,
    output logic        rready,

    // timer
    output logic        clint_rd,
    output logic        clint_idx,
    input  logic [31:0] clint_rdata,

    // lanes
    input  axi_w_t      wlane,
    output logic [31:0] rword,
    input  logic [31:0] rdata_al
);

    typedef enum logic [2:0] {
        st_idle,
        st_clint,
        st_aw,
        st_w,
        st_b,
        st_ar,
        st_r
    } state_e;

    state_e   state;
    lsu_req_t req_q;
    axi_w_t   w_q;
    logic     accept;
    logic     hit;
    logic     fin;
    lsu_rsp_t rsp_nxt;

    assign accept = req_valid && (state == st_idle);

    // timer window decode, done once on the incoming address
    assign hit = (req.addr.full >= clint_base) && (req.addr.full <= clint_last);

    // timer read starts in the request cycle so data is back one cycle later
    assign clint_rd  = accept && req.ren && !req.wen && hit;
    assign clint_idx = req.addr.part.word_idx[0];

    assign busy  = (state != st_idle);
    assign rword = (state == st_clint) ? clint_rdata : r.data;
    assign w     = w_q;

    // address channels: single beat, id 0
    always_comb begin
        aw.addr  = req_q.addr.full;
        aw.size  = 3'(req_q.size);
        aw.len   = '0;
        aw.id    = '0;
        aw.burst = '0;
        ar.addr  = req_q.addr.full;
        ar.size  = 3'(req_q.size);
        ar.len   = '0;
        ar.id    = '0;
        ar.burst = '0;
    end

    // completion and the response it carries
    always_comb begin
        fin           = 1'b0;
        rsp_nxt.rdata = '0;
        rsp_nxt.err   = 1'b0;
        case (state)
            st_idle: begin
                if (accept && req.wen && hit) begin
                    // mtime is read-only
                    fin         = 1'b1;
                    rsp_nxt.err = 1'b1;
                end else if (accept && !req.wen && !req.ren) begin
                    fin = 1'b1;
                end
            end
            st_clint: begin
                fin           = 1'b1;
                rsp_nxt.rdata = rdata_al;
            end
            st_b: begin
                fin         = bvalid && bready;
                rsp_nxt.err = (b.resp != axi_okay);
            end
            st_r: begin
                fin           = rvalid && rready;
                rsp_nxt.rdata = rdata_al;
                rsp_nxt.err   = (r.resp != axi_okay);
            end
            default: begin
                fin = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            done    <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            done <= fin;
            case (state)
                st_idle: begin
                    if (accept && req.wen && !hit) begin
                        state   <= st_aw;
                        awvalid <= 1'b1;
                    end else if (accept && !req.wen && req.ren && hit) begin
                        state <= st_clint;
                    end else if (accept && !req.wen && req.ren) begin
                        state   <= st_ar;
                        arvalid <= 1'b1;
                    end
                end
                st_clint: begin
                    state <= st_idle;
                end
                st_aw: begin
                    // W follows the AW handshake
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        state   <= st_w;
                    end
                end
                st_w: begin
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                        bready <= 1'b1;
                        state  <= st_b;
                    end
                end
                st_b: begin
                    if (bvalid && bready) begin
                        bready <= 1'b0;
                        state  <= st_idle;
                    end
                end
                st_ar: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= st_r;
                    end
                end
                st_r: begin
                    if (rvalid && rready) begin
                        rready <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // request, write beat and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
            w_q   <= wlane;
        end
        if (fin) begin
            rsp <= rsp_nxt;
        end
    end

endmodule

// ==== lsu_lanes.sv ====
`timescale 1ns/1ps

module lsu_lanes import lsu_pkg::*; (
    input  lsu_req_t    req,
    input  logic [31:0] rword,
    output axi_w_t      wlane,
    output logic [31:0] rdata
);

    logic [1:0]  off;
    logic [4:0]  shamt;
    logic [31:0] rshift;

    assign off   = req.addr.part.byte_off;
    // 8 bits per byte lane
    assign shamt = {off, 3'b000};

    // store side: strobes and lane placement
    always_comb begin
        case (req.size)
            size_byte: begin
                wlane.strb = 4'b0001 << off;
            end
            size_half: begin
                // upper or lower halfword, bit 0 of the offset is ignored
                wlane.strb = off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wlane.strb = 4'b1111;
            end
        endcase
        wlane.data = req.wdata << shamt;
        // single beat only
        wlane.last = 1'b1;
    end

    // load side: bring the addressed lanes down to bit 0
    assign rshift = rword >> shamt;

    always_comb begin
        case (req.size)
            size_byte: begin
                rdata = {{24{req.sign & rshift[7]}}, rshift[7:0]};
            end
            size_half: begin
                rdata = {{16{req.sign & rshift[15]}}, rshift[15:0]};
            end
            default: begin
                rdata = rshift;
            end
        endcase
    end

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // timer window, two 32-bit words of mtime
    localparam logic [31:0] clint_base = 32'ha0000048;
    localparam logic [31:0] clint_last = 32'ha000004f;

    // AXI response codes
    localparam logic [1:0] axi_okay = 2'b00;

    // access size, same encoding as AXI axsize for 1, 2 and 4 bytes
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_e;

    // address seen whole, or as word index plus byte lane
    typedef union packed {
        logic [31:0] full;
        struct packed {
            logic [29:0] word_idx;
            logic [1:0]  byte_off;
        } part;
    } lsu_addr_u;

    // core side request
    typedef struct packed {
        logic        wen;
        logic        ren;
        logic        sign;
        lsu_size_e   size;
        lsu_addr_u   addr;
        logic [31:0] wdata;
    } lsu_req_t;

    // core side response, valid with done
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    // AXI4 write address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic [7:0]  len;
        logic [3:0]  id;
        logic [1:0]  burst;
    } axi_aw_t;

    // AXI4 read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic [7:0]  len;
        logic [3:0]  id;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

// ==== lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam logic [31:0] mem_base = 32'h80000000;
    localparam logic [31:0] bad_addr = 32'h80000100;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    lsu_req_t req;
    logic     busy;
    logic     done;
    lsu_rsp_t rsp;
    axi_aw_t  aw;
    axi_w_t   w;
    axi_b_t   b;
    axi_ar_t  ar;
    axi_r_t   r;
    logic     awvalid, awready, wvalid, wready, bvalid, bready;
    logic     arvalid, arready, rvalid, rready;

    logic [7:0] shadow [64];
    int errors = 0;
    int test_errs = 0;
    int tests = 0;
    int failed = 0;
    int req_cnt = 0;
    int cyc = 0;
    int done_cnt = 0;
    int axi_cnt = 0;
    int lat;
    int t0;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    tb_axi_mem #(.err_addr(bad_addr)) u_mem (.*);

    lsu_top #(.mtime_step(1)) dut (.*);

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (done) done_cnt <= done_cnt + 1;
        if (awvalid || arvalid || wvalid) axi_cnt <= axi_cnt + 1;
    end

    function automatic logic [3:0] lane_mask(int size, int off);
        if (size == 0) return 4'(1 << off);
        if (size == 1) return (off >= 2) ? 4'b1100 : 4'b0011;
        return 4'b1111;
    endfunction

    function automatic logic [31:0] expect_load(int size, logic sign, int k, int off);
        logic [31:0] word;
        word = {shadow[4*k+3], shadow[4*k+2], shadow[4*k+1], shadow[4*k]} >> (8 * off);
        if (size == 0) begin
            return (sign && word[7]) ? {24'hffffff, word[7:0]} : {24'h0, word[7:0]};
        end
        if (size == 1) begin
            return (sign && word[15]) ? {16'hffff, word[15:0]} : {16'h0, word[15:0]};
        end
        return word;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    // drives one request and waits for its done pulse
    task automatic do_access(logic wen, logic ren, logic sign, int size,
                             logic [31:0] addr, logic [31:0] wdata);
        int n;
        n = 0;
        while (busy && n < 200) begin
            @(posedge clk);
            #1 n++;
        end
        if (busy) begin
            $display("timeout waiting for busy to drop");
            test_errs++;
        end
        req.wen       = wen;
        req.ren       = ren;
        req.sign      = sign;
        req.size      = lsu_size_e'(size);
        req.addr.full = addr;
        req.wdata     = wdata;
        req_valid     = 1'b1;
        t0            = cyc;
        req_cnt++;
        @(posedge clk);
        #1 req_valid = 1'b0;
        lat = 1;
        while (!done && lat < 200) begin
            @(posedge clk);
            #1 lat++;
        end
        if (!done) begin
            $display("timeout waiting for done at address %h", addr);
            test_errs++;
        end
    endtask

    task automatic store(int size, int k, int off, logic [31:0] data);
        logic [3:0]  m;
        logic [31:0] sh;
        m  = lane_mask(size, off);
        sh = data << (8 * off);
        do_access(1'b1, 1'b0, 1'b0, size, mem_base + 32'(4 * k + off), data);
        check_val("rsp.err", 32'(rsp.err), 0);
        for (int i = 0; i < 4; i++) begin
            if (m[i]) shadow[4*k+i] = sh[8*i +: 8];
        end
    endtask

    task automatic load(int size, logic sign, int k, int off);
        do_access(1'b0, 1'b1, sign, size, mem_base + 32'(4 * k + off), '0);
        check_val("rsp.rdata", rsp.rdata, expect_load(size, sign, k, off));
        check_val("rsp.err", 32'(rsp.err), 0);
    endtask

    task automatic finish_test(string name);
        tests++;
        if (test_errs != 0) failed++;
        $display("test %s: %s (%0d errors)", name, test_errs ? "FAIL" : "ok", test_errs);
        errors += test_errs;
        test_errs = 0;
    endtask

    initial begin
        int s;
        int off;
        int a0;
        int v0;
        void'($urandom(32'h90b2));
        req_valid = 1'b0;
        req = '0;
        s = 0;
        while (!rst_n && s < 200) begin
            @(posedge clk);
            s++;
        end
        @(posedge clk);
        #1;

        // fill known contents before trying every size at every legal offset
        for (int k = 0; k < 16; k++) store(2, k, 0, $urandom);
        for (int sz = 0; sz < 3; sz++) begin
            for (off = 0; off < 4; off += (1 << sz)) begin
                store(sz, sz * 4 + off, off, $urandom);
                load(2, 1'b0, sz * 4 + off, 0);
            end
        end
        finish_test("stores");

        for (int sz = 0; sz < 3; sz++) begin
            for (off = 0; off < 4; off += (1 << sz)) begin
                load(sz, 1'b0, off + 3, off);
                load(sz, 1'b1, off + 3, off);
            end
        end
        finish_test("loads");

        // mixed traffic under random slave delays
        for (int n = 0; n < 60; n++) begin
            s   = $urandom % 3;
            off = (s == 2) ? 0 : (($urandom % 4) & ~((1 << s) - 1));
            if ($urandom % 2) store(s, $urandom % 16, off, $urandom);
            else load(s, 1'(($urandom % 2)), $urandom % 16, off);
        end
        repeat (2) @(posedge clk);
        #1 check_val("done count", done_cnt, req_cnt);
        finish_test("backpressure");

        a0 = axi_cnt;
        do_access(1'b0, 1'b1, 1'b0, 2, clint_base, '0);
        check_val("timer latency", lat, 2);
        v0 = t0;
        s  = rsp.rdata;
        repeat (1 + ($urandom % 7)) @(posedge clk);
        #1 do_access(1'b0, 1'b1, 1'b0, 2, clint_base, '0);
        check_val("timer latency", lat, 2);
        check_val("mtime delta", rsp.rdata - s, t0 - v0);
        check_val("axi valid count", axi_cnt, a0);
        finish_test("timer");

        do_access(1'b0, 1'b1, 1'b0, 2, bad_addr, '0);
        check_val("rsp.err", 32'(rsp.err), 1);
        do_access(1'b1, 1'b0, 1'b0, 2, bad_addr, 32'h5a5a5a5a);
        check_val("rsp.err", 32'(rsp.err), 1);
        a0 = axi_cnt;
        do_access(1'b1, 1'b0, 1'b0, 2, clint_base + 4, 32'h1);
        check_val("timer store latency", lat, 1);
        check_val("rsp.err", 32'(rsp.err), 1);
        check_val("axi valid count", axi_cnt, a0);
        finish_test("errors");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps

// the core keeps req steady from req_valid until done,
// the lanes align load data from it at completion
module lsu_top import lsu_pkg::*; #(
    parameter int unsigned mtime_step = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  lsu_req_t req,
    output logic     busy,
    output logic     done,
    output lsu_rsp_t rsp,
    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,
    output axi_w_t   w,
    output logic     wvalid,
    input  logic     wready,
    input  axi_b_t   b,
    input  logic     bvalid,
    output logic     bready,
    output axi_ar_t  ar,
    output logic     arvalid,
    input  logic     arready,
    input  axi_r_t   r,
    input  logic     rvalid,
    output logic     rready
);

    axi_w_t      wlane;
    logic [31:0] rword;
    logic [31:0] rdata_al;
    logic        clint_rd;
    logic        clint_idx;
    logic [31:0] clint_rdata;

    lsu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .done        (done),
        .rsp         (rsp),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .b           (b),
        .bvalid      (bvalid),
        .bready      (bready),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .clint_rd    (clint_rd),
        .clint_idx   (clint_idx),
        .clint_rdata (clint_rdata),
        .wlane       (wlane),
        .rword       (rword),
        .rdata_al    (rdata_al)
    );

    lsu_lanes u_lanes (
        .req   (req),
        .rword (rword),
        .wlane (wlane),
        .rdata (rdata_al)
    );

    lsu_clint #(
        .mtime_step (mtime_step)
    ) u_clint (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (clint_rd),
        .idx   (clint_idx),
        .rdata (clint_rdata)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run, any build or run error counts as a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f flist.f > sim.log 2>&1 \
    && ./obj_dir/Vlsu_tb >> sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem import lsu_pkg::*; #(
    parameter logic [31:0] err_addr = 32'h80000100
) (
    input  logic    clk,
    input  logic    rst_n,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);

    logic [7:0]  mem [1024];
    logic [31:0] aw_addr;
    logic [31:0] ar_addr;
    logic        aw_got;
    logic        b_pend;
    logic        ar_got;

    // fill pattern mixes every address bit
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'((i * 29) ^ (i >> 3));
        end
    end

    function automatic logic [1:0] resp_for(logic [31:0] addr);
        return (addr[31:2] == err_addr[31:2]) ? 2'b10 : axi_okay;
    endfunction

    // write path, ready and response delays come from $urandom
    always @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            b_pend  <= 1'b0;
            b       <= '0;
        end else begin
            if (awvalid && awready) begin
                aw_addr <= aw.addr;
                aw_got  <= 1'b1;
                awready <= 1'b0;
            end else begin
                awready <= !aw_got && (($urandom % 3) != 0);
            end
            if (wvalid && wready) begin
                for (int i = 0; i < 4; i++) begin
                    if (w.strb[i]) begin
                        mem[{aw_addr[9:2], 2'(i)}] <= w.data[8*i +: 8];
                    end
                end
                wready <= 1'b0;
                b_pend <= 1'b1;
            end else begin
                wready <= aw_got && !b_pend && (($urandom % 3) != 0);
            end
            if (b_pend && !bvalid && (($urandom % 2) != 0)) begin
                bvalid <= 1'b1;
                b.resp <= resp_for(aw_addr);
                b.id   <= '0;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
                aw_got <= 1'b0;
            end
        end
    end

    // read path
    always @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            ar_got  <= 1'b0;
            r       <= '0;
        end else begin
            if (arvalid && arready) begin
                ar_addr <= ar.addr;
                ar_got  <= 1'b1;
                arready <= 1'b0;
            end else begin
                arready <= !ar_got && (($urandom % 3) != 0);
            end
            if (ar_got && !rvalid && (($urandom % 2) != 0)) begin
                rvalid <= 1'b1;
                r.data <= {mem[{ar_addr[9:2], 2'd3}], mem[{ar_addr[9:2], 2'd2}],
                           mem[{ar_addr[9:2], 2'd1}], mem[{ar_addr[9:2], 2'd0}]};
                r.resp <= resp_for(ar_addr);
                r.last <= 1'b1;
                r.id   <= '0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                ar_got <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule
